//--- list.f
+incdir+.
cpu_pkg.sv
cpu_regfile.sv
cpu_alu.sv
cpu_sequencer.sv
cpu_core.sv
cpu_chk.sv
tb_cpu_monitor.sv
tb_cpu.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = tb_cpu
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

//--- tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_params.svh"

module tb_cpu;

   localparam logic [15:0] VAL_A = 16'h00F0;
   localparam logic [15:0] VAL_B = 16'h0F3C;

   logic        wire_clock;
   logic        resetStage;
   logic [15:0] ram_rdata;
   wire  [15:0] ram_addr;
   wire  [15:0] ram_wdata;
   wire         ram_we;

   logic [15:0] mem [256];
   logic [15:0] tbl_addr [256];
   logic [15:0] tbl_word [256];
   int          tbl_n;
   logic [15:0] here;
   logic [15:0] exp_addr [64];
   logic [15:0] exp_data [64];
   int          exp_n;
   int          seen_count;
   int          err_count;
   int          cycles;
   logic        timed_out;

   cpu_core u_cpu_core (
      .wire_clock (wire_clock),
      .resetStage (resetStage),
      .ram_rdata  (ram_rdata),
      .ram_addr   (ram_addr),
      .ram_wdata  (ram_wdata),
      .ram_we     (ram_we)
   );

   tb_cpu_monitor u_mon (
      .wire_clock (wire_clock),
      .resetStage (resetStage),
      .ram_we     (ram_we),
      .ram_addr   (ram_addr),
      .ram_wdata  (ram_wdata),
      .exp_addr   (exp_addr),
      .exp_data   (exp_data),
      .exp_count  (exp_n),
      .seen_count (seen_count),
      .err_count  (err_count)
   );

   initial begin
      wire_clock = 1'b0;
      forever #2 wire_clock = ~wire_clock;
   end

   // one cycle read latency
   always @(posedge wire_clock) begin
      if (ram_we) begin
         mem[ram_addr[7:0]] <= ram_wdata;
      end
      ram_rdata <= mem[ram_addr[7:0]];
   end

   function automatic logic [15:0] rfmt(input logic [5:0] opc, input logic [2:0] rx,
                                        input logic [2:0] ry, input logic [2:0] rz,
                                        input logic c);
      return {opc, rx, ry, rz, c};
   endfunction

   task automatic put(input logic [15:0] a, input logic [15:0] w);
      tbl_addr[tbl_n] = a;
      tbl_word[tbl_n] = w;
      tbl_n = tbl_n + 1;
   endtask

   task automatic emit(input logic [15:0] w);
      put(here, w);
      here = here + 16'd1;
   endtask

   task automatic expect_write(input logic [15:0] a, input logic [15:0] d);
      exp_addr[exp_n[5:0]] = a;
      exp_data[exp_n[5:0]] = d;
      exp_n = exp_n + 1;
   endtask

   task automatic op_word(input logic [5:0] opc, input logic [2:0] rx,
                          input logic [15:0] w);
      emit(rfmt(opc, rx, 3'd0, 3'd0, 1'b0));
      emit(w);
   endtask

   task automatic op_reg(input logic [5:0] opc, input logic [2:0] rx,
                         input logic [2:0] ry, input logic [2:0] rz, input logic c);
      emit(rfmt(opc, rx, ry, rz, c));
   endtask

   task automatic op_jmp(input logic [3:0] cond, input logic [15:0] target);
      emit({`OPC_JMP, cond, 6'b000000});
      emit(target);
   endtask

   // a taken jump hops over the store
   task automatic skip_store(input logic [3:0] cond, input logic [2:0] rs,
                             input logic [15:0] addr);
      logic [15:0] target;
      target = here + 16'd4;
      op_jmp(cond, target);
      op_word(`OPC_STORE, rs, addr);
   endtask

   task automatic mark(input logic [15:0] val, input logic [15:0] addr);
      op_word(`OPC_LOADN, 3'd6, val);
      op_word(`OPC_STORE, 3'd6, addr);
      expect_write(addr, val);
   endtask

   task automatic alu_store(input logic [5:0] opc, input logic [2:0] ry,
                            input logic [2:0] rz, input logic [15:0] addr,
                            input logic [15:0] val);
      op_reg(opc, 3'd3, ry, rz, 1'b0);
      op_word(`OPC_STORE, 3'd3, addr);
      expect_write(addr, val);
   endtask

   task automatic build_program;
      put(16'h0090, 16'hBEEF);
      put(16'h0091, 16'h5A5A);
      op_word(`OPC_LOADN, 3'd1, 16'h1234);
      op_word(`OPC_STORE, 3'd1, 16'h00C0);
      expect_write(16'h00C0, 16'h1234);
      op_word(`OPC_LOAD, 3'd2, 16'h0090);
      op_word(`OPC_STORE, 3'd2, 16'h00C1);
      expect_write(16'h00C1, 16'hBEEF);
      op_word(`OPC_LOADN, 3'd3, 16'h0091);
      op_word(`OPC_LOADN, 3'd4, 16'h00C2);
      op_reg(`OPC_LOADI, 3'd5, 3'd3, 3'd0, 1'b0);
      op_reg(`OPC_STOREI, 3'd4, 3'd5, 3'd0, 1'b0);
      expect_write(16'h00C2, 16'h5A5A);
      op_reg(`OPC_MOV, 3'd6, 3'd5, 3'd0, 1'b0);
      op_word(`OPC_STORE, 3'd6, 16'h00C3);
      expect_write(16'h00C3, 16'h5A5A);
      op_word(`OPC_LOADN, 3'd1, VAL_A);
      op_word(`OPC_LOADN, 3'd2, VAL_B);
      alu_store(`OPC_ADD, 3'd1, 3'd2, 16'h00C4, VAL_A + VAL_B);
      alu_store(`OPC_SUB, 3'd2, 3'd1, 16'h00C5, VAL_B - VAL_A);
      alu_store(`OPC_AND, 3'd1, 3'd2, 16'h00C6, VAL_A & VAL_B);
      alu_store(`OPC_OR, 3'd1, 3'd2, 16'h00C7, VAL_A | VAL_B);
      alu_store(`OPC_XOR, 3'd1, 3'd2, 16'h00C8, VAL_A ^ VAL_B);
      alu_store(`OPC_NOT, 3'd1, 3'd0, 16'h00C9, ~VAL_A);
      // wrong path marker, never expected
      op_word(`OPC_LOADN, 3'd7, 16'hEEEE);
      // ffff + 1 gives zero with carry
      op_word(`OPC_LOADN, 3'd1, 16'hFFFF);
      op_word(`OPC_LOADN, 3'd2, 16'h0001);
      op_reg(`OPC_ADD, 3'd3, 3'd1, 3'd2, 1'b0);
      skip_store(`COND_Z, 3'd7, 16'h00DF);
      mark(16'h0A01, 16'h00D0);
      skip_store(`COND_C, 3'd7, 16'h00DF);
      mark(16'h0A02, 16'h00D1);
      skip_store(`COND_NZ, 3'd6, 16'h00D2);
      expect_write(16'h00D2, 16'h0A02);
      op_reg(`OPC_ADD, 3'd4, 3'd2, 3'd2, 1'b1);
      op_word(`OPC_STORE, 3'd4, 16'h00CA);
      expect_write(16'h00CA, 16'h0001 + 16'h0001 + 16'h0001);
      op_reg(`OPC_CMP, 3'd1, 3'd2, 3'd0, 1'b0);
      skip_store(`COND_GT, 3'd7, 16'h00DF);
      mark(16'h0A03, 16'h00D3);
      skip_store(`COND_NE, 3'd7, 16'h00DF);
      mark(16'h0A04, 16'h00D4);
      skip_store(`COND_EQ, 3'd6, 16'h00D5);
      expect_write(16'h00D5, 16'h0A04);
      op_reg(`OPC_CMP, 3'd2, 3'd1, 3'd0, 1'b0);
      skip_store(`COND_LT, 3'd7, 16'h00DF);
      mark(16'h0A05, 16'h00D6);
      op_reg(`OPC_CMP, 3'd2, 3'd2, 3'd0, 1'b0);
      skip_store(`COND_EQ, 3'd7, 16'h00DF);
      mark(16'h0A06, 16'h00D7);
      skip_store(`COND_ALWAYS, 3'd7, 16'h00DF);
      mark(16'h0A07, 16'h00D8);
      // park on a jump to itself
      op_jmp(`COND_ALWAYS, here);
   endtask

   initial begin
      resetStage = 1'b1;
      ram_rdata  = 16'h0000;
      tbl_n      = 0;
      exp_n      = 0;
      here       = 16'h0000;
      timed_out  = 1'b0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = 16'(i) ^ 16'h5C3A;
      end
      build_program();
      for (int i = 0; i < tbl_n; i++) begin
         mem[tbl_addr[i][7:0]] = tbl_word[i];
      end
      repeat (3) @(posedge wire_clock);
      resetStage <= 1'b0;
      for (int i = 0; i < exp_n; i++) begin
         if (!timed_out) begin
            cycles = 0;
            while (seen_count <= i && cycles < 200) begin
               @(negedge wire_clock);
               cycles = cycles + 1;
            end
            if (seen_count <= i) begin
               $display("timed out after 200 cycles waiting for memory write %0d", i);
               timed_out = 1'b1;
            end
         end
      end
      @(negedge wire_clock);
      $display("errors: %0d, writes seen: %0d of %0d", err_count, seen_count, exp_n);
      if (err_count == 0 && !timed_out) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_cpu_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_monitor (
   input  wire         wire_clock,
   input  wire         resetStage,
   input  wire         ram_we,
   input  wire  [15:0] ram_addr,
   input  wire  [15:0] ram_wdata,
   input  logic [15:0] exp_addr [64],
   input  logic [15:0] exp_data [64],
   input  int          exp_count,
   output int          seen_count,
   output int          err_count
);

   logic was_rst;

   always @(posedge wire_clock) begin
      int         errs;
      logic [5:0] idx;
      errs = err_count;
      idx  = seen_count[5:0];
      was_rst <= resetStage;
      if (resetStage) begin
         seen_count <= 0;
         err_count  <= 0;
      end else begin
         // first cycle out of reset fetches from address 0
         if (was_rst && ram_addr != 16'h0000) begin
            $display("FAIL ram_addr expected %h got %h", 16'h0000, ram_addr);
            errs = errs + 1;
         end
         if (ram_we) begin
            if (seen_count < exp_count) begin
               if (ram_addr != exp_addr[idx]) begin
                  $display("FAIL ram_addr expected %h got %h", exp_addr[idx], ram_addr);
                  errs = errs + 1;
               end
               if (ram_wdata != exp_data[idx]) begin
                  $display("FAIL ram_wdata expected %h got %h", exp_data[idx], ram_wdata);
                  errs = errs + 1;
               end
            end else begin
               $display("unexpected memory write at address %h", ram_addr);
               errs = errs + 1;
            end
            seen_count <= seen_count + 1;
         end
         err_count <= errs;
      end
   end

endmodule

`default_nettype wire

//--- cpu_chk.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_chk (
   input wire       wire_clock,
   input wire       resetStage,
   input wire       ram_we,
   input wire [2:0] stage
);

   // a write strobe lasts one cycle
   a_we_single: assert property (@(posedge wire_clock) disable iff (resetStage)
      ram_we |=> !ram_we)
      else $error("ram_we high for two cycles");

   a_we_after_reset: assert property (@(posedge wire_clock)
      resetStage |=> !ram_we)
      else $error("ram_we high in the first cycle after reset");

   // longest instruction ends in the fourth execute stage
   a_restart_fetch: assert property (@(posedge wire_clock) disable iff (resetStage)
      stage <= 3'd5)
      else $error("stage ran past the last execute stage");

endmodule

bind cpu_sequencer cpu_chk u_chk (
   .wire_clock (wire_clock),
   .resetStage (resetStage),
   .ram_we     (ram_we),
   .stage      (stage)
);

`default_nettype wire

//--- cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
   input  wire                   wire_clock,
   input  wire                   resetStage,
   input  wire cpu_pkg::word_t   ram_rdata,
   output cpu_pkg::word_t        ram_addr,
   output cpu_pkg::word_t        ram_wdata,
   output logic                  ram_we
);

   cpu_pkg::reg_idx_t   rd_a_idx;
   cpu_pkg::reg_idx_t   rd_b_idx;
   cpu_pkg::word_t      rd_a_data;
   cpu_pkg::word_t      rd_b_data;
   logic                wr_en;
   cpu_pkg::reg_idx_t   wr_idx;
   cpu_pkg::word_t      wr_data;
   cpu_pkg::alu_op_t    alu_op;
   logic                alu_en;
   logic                alu_use_carry;
   logic [3:0]          alu_cond;
   cpu_pkg::word_t      alu_result;
   logic                cond_true;

   cpu_sequencer u_seq (
      .wire_clock    (wire_clock),
      .resetStage    (resetStage),
      .ram_rdata     (ram_rdata),
      .ram_addr      (ram_addr),
      .ram_wdata     (ram_wdata),
      .ram_we        (ram_we),
      .rd_a_idx      (rd_a_idx),
      .rd_b_idx      (rd_b_idx),
      .rd_a_data     (rd_a_data),
      .rd_b_data     (rd_b_data),
      .wr_en         (wr_en),
      .wr_idx        (wr_idx),
      .wr_data       (wr_data),
      .alu_op        (alu_op),
      .alu_en        (alu_en),
      .alu_use_carry (alu_use_carry),
      .alu_cond      (alu_cond),
      .alu_result    (alu_result),
      .cond_true     (cond_true)
   );

   cpu_regfile u_regs (
      .wire_clock (wire_clock),
      .resetStage (resetStage),
      .rd_a_idx   (rd_a_idx),
      .rd_b_idx   (rd_b_idx),
      .rd_a_data  (rd_a_data),
      .rd_b_data  (rd_b_data),
      .wr_en      (wr_en),
      .wr_idx     (wr_idx),
      .wr_data    (wr_data)
   );

   // operands come straight from the two read ports
   cpu_alu u_alu (
      .wire_clock    (wire_clock),
      .resetStage    (resetStage),
      .op_a          (rd_a_data),
      .op_b          (rd_b_data),
      .alu_op        (alu_op),
      .alu_en        (alu_en),
      .alu_use_carry (alu_use_carry),
      .alu_cond      (alu_cond),
      .result        (alu_result),
      .cond_true     (cond_true)
   );

endmodule

`default_nettype wire

//--- cpu_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_params.svh"

module cpu_sequencer (
   input  wire                      wire_clock,
   input  wire                      resetStage,
   input  wire cpu_pkg::word_t      ram_rdata,
   output cpu_pkg::word_t           ram_addr,
   output cpu_pkg::word_t           ram_wdata,
   output logic                     ram_we,
   output cpu_pkg::reg_idx_t        rd_a_idx,
   output cpu_pkg::reg_idx_t        rd_b_idx,
   input  wire cpu_pkg::word_t      rd_a_data,
   input  wire cpu_pkg::word_t      rd_b_data,
   output logic                     wr_en,
   output cpu_pkg::reg_idx_t        wr_idx,
   output cpu_pkg::word_t           wr_data,
   output cpu_pkg::alu_op_t         alu_op,
   output logic                     alu_en,
   output logic                     alu_use_carry,
   output logic [3:0]               alu_cond,
   input  wire cpu_pkg::word_t      alu_result,
   input  wire                      cond_true
);

   // stages 0 and 1 fetch, execute starts at 2
   localparam logic [2:0] ST_FETCH = 3'd0;
   localparam logic [2:0] ST_IR    = 3'd1;
   localparam logic [2:0] ST_EX0   = 3'd2;
   localparam logic [2:0] ST_EX1   = 3'd3;
   localparam logic [2:0] ST_EX2   = 3'd4;
   localparam logic [2:0] ST_EX3   = 3'd5;

   logic [2:0]             stage;
   cpu_pkg::word_t         pc;
   cpu_pkg::instr_u        ir;
   cpu_pkg::word_t         dir_addr;
   logic [`CPU_OPC_W-1:0]  opc;
   logic                   is_alu;
   logic                   is_direct;
   logic                   uses_word;
   logic                   instr_done;

   assign opc           = ir.r.opcode;
   assign alu_cond      = ir.j.cond;
   assign alu_use_carry = ir.r.with_carry;
   assign is_direct     = (opc == `OPC_LOAD) || (opc == `OPC_STORE);
   assign uses_word     = is_direct || (opc == `OPC_LOADN) || (opc == `OPC_JMP);
   assign alu_en        = is_alu && (stage == ST_EX1);

   always_comb begin
      is_alu = 1'b1;
      case (opc)
         `OPC_ADD: alu_op = cpu_pkg::ALU_ADD;
         `OPC_SUB: alu_op = cpu_pkg::ALU_SUB;
         `OPC_AND: alu_op = cpu_pkg::ALU_AND;
         `OPC_OR:  alu_op = cpu_pkg::ALU_OR;
         `OPC_XOR: alu_op = cpu_pkg::ALU_XOR;
         `OPC_NOT: alu_op = cpu_pkg::ALU_NOT;
         `OPC_CMP: alu_op = cpu_pkg::ALU_CMP;
         default: begin
            is_alu = 1'b0;
            alu_op = cpu_pkg::ALU_PASS;
         end
      endcase
   end

   // last execute stage of the current instruction
   always_comb begin
      if (stage < ST_EX0) begin
         instr_done = 1'b0;
      end else if (is_direct) begin
         instr_done = (stage == ST_EX3);
      end else if (uses_word || is_alu || opc == `OPC_LOADI || opc == `OPC_STOREI) begin
         instr_done = (stage == ST_EX1);
      end else begin
         // mov and unknown opcodes
         instr_done = 1'b1;
      end
   end

   always_comb begin
      ram_addr  = pc;
      ram_wdata = rd_a_data;
      ram_we    = 1'b0;
      rd_a_idx  = ir.r.ry;
      rd_b_idx  = ir.r.rz;
      wr_en     = 1'b0;
      wr_idx    = ir.r.rx;
      wr_data   = alu_result;
      if (stage >= ST_EX0) begin
         case (opc)
            `OPC_LOADN: begin
               wr_data = ram_rdata;
               wr_en   = (stage == ST_EX1);
            end
            `OPC_LOAD: begin
               if (stage >= ST_EX2) begin
                  ram_addr = dir_addr;
               end
               wr_data = ram_rdata;
               wr_en   = (stage == ST_EX3);
            end
            `OPC_STORE: begin
               rd_a_idx = ir.r.rx;
               if (stage >= ST_EX2) begin
                  ram_addr = dir_addr;
               end
               ram_we = (stage == ST_EX3);
            end
            `OPC_LOADI: begin
               ram_addr = rd_a_data;
               wr_data  = ram_rdata;
               wr_en    = (stage == ST_EX1);
            end
            `OPC_STOREI: begin
               rd_a_idx  = ir.r.rx;
               rd_b_idx  = ir.r.ry;
               ram_addr  = rd_a_data;
               ram_wdata = rd_b_data;
               ram_we    = (stage == ST_EX1);
            end
            `OPC_MOV: begin
               wr_data = rd_a_data;
               wr_en   = 1'b1;
            end
            `OPC_CMP: begin
               // compares rx with ry, no write back
               rd_a_idx = ir.r.rx;
               rd_b_idx = ir.r.ry;
            end
            default: begin
               wr_en = is_alu && (stage == ST_EX1);
            end
         endcase
      end
   end

   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         stage <= ST_FETCH;
         pc    <= `CPU_PC_RESET;
         ir    <= '0;
      end else begin
         if (instr_done) begin
            stage <= ST_FETCH;
         end else begin
            stage <= stage + 3'd1;
         end
         if (stage == ST_IR) begin
            ir <= ram_rdata;
         end
         if (stage == ST_EX1 && opc == `OPC_JMP && cond_true) begin
            pc <= ram_rdata;
         end else if (stage == ST_IR || (stage == ST_EX1 && uses_word)) begin
            pc <= pc + cpu_pkg::word_t'(1);
         end
      end
   end

   // address word of load and store
   always_ff @(posedge wire_clock) begin
      if (stage == ST_EX1 && is_direct) begin
         dir_addr <= ram_rdata;
      end
   end

endmodule

`default_nettype wire

//--- cpu_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_params.svh"

module cpu_alu (
   input  wire                      wire_clock,
   input  wire                      resetStage,
   input  wire cpu_pkg::word_t      op_a,
   input  wire cpu_pkg::word_t      op_b,
   input  wire cpu_pkg::alu_op_t    alu_op,
   input  wire                      alu_en,
   input  wire                      alu_use_carry,
   input  wire [3:0]                alu_cond,
   output cpu_pkg::word_t           result,
   output logic                     cond_true
);

   cpu_pkg::word_t         flags;
   logic [`CPU_WORD_W:0]   sum;
   logic                   carry_in;

   // top bit of sum is carry out for add, borrow for sub
   always_comb begin
      carry_in = alu_use_carry & flags[`FLAG_C];
      sum      = '0;
      case (alu_op)
         cpu_pkg::ALU_ADD: begin
            sum    = {1'b0, op_a} + {1'b0, op_b} + {{`CPU_WORD_W{1'b0}}, carry_in};
            result = sum[`CPU_WORD_W-1:0];
         end
         cpu_pkg::ALU_SUB: begin
            sum    = {1'b0, op_a} - {1'b0, op_b} - {{`CPU_WORD_W{1'b0}}, carry_in};
            result = sum[`CPU_WORD_W-1:0];
         end
         cpu_pkg::ALU_AND: result = op_a & op_b;
         cpu_pkg::ALU_OR:  result = op_a | op_b;
         cpu_pkg::ALU_XOR: result = op_a ^ op_b;
         cpu_pkg::ALU_NOT: result = ~op_a;
         default:          result = op_a;
      endcase
   end

   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         flags <= '0;
      end else if (alu_en) begin
         case (alu_op)
            cpu_pkg::ALU_CMP: begin
               // unsigned compare
               flags[`FLAG_GT] <= (op_a > op_b);
               flags[`FLAG_LT] <= (op_a < op_b);
               flags[`FLAG_EQ] <= (op_a == op_b);
            end
            cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB: begin
               flags[`FLAG_Z] <= (result == '0);
               flags[`FLAG_C] <= sum[`CPU_WORD_W];
            end
            default: begin
               flags[`FLAG_Z] <= (result == '0);
               flags[`FLAG_C] <= 1'b0;
            end
         endcase
      end
   end

   always_comb begin
      case (alu_cond)
         `COND_ALWAYS: cond_true = 1'b1;
         `COND_EQ:     cond_true = flags[`FLAG_EQ];
         `COND_NE:     cond_true = ~flags[`FLAG_EQ];
         `COND_Z:      cond_true = flags[`FLAG_Z];
         `COND_NZ:     cond_true = ~flags[`FLAG_Z];
         `COND_C:      cond_true = flags[`FLAG_C];
         `COND_NC:     cond_true = ~flags[`FLAG_C];
         `COND_GT:     cond_true = flags[`FLAG_GT];
         `COND_LT:     cond_true = flags[`FLAG_LT];
         default:      cond_true = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- cpu_regfile.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_params.svh"

module cpu_regfile (
   input  wire                      wire_clock,
   input  wire                      resetStage,
   input  wire cpu_pkg::reg_idx_t   rd_a_idx,
   input  wire cpu_pkg::reg_idx_t   rd_b_idx,
   output cpu_pkg::word_t           rd_a_data,
   output cpu_pkg::word_t           rd_b_data,
   input  wire                      wr_en,
   input  wire cpu_pkg::reg_idx_t   wr_idx,
   input  wire cpu_pkg::word_t      wr_data
);

   cpu_pkg::word_t regs [`CPU_NREGS];

   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         for (int i = 0; i < `CPU_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // reads see the old value during a write
   assign rd_a_data = regs[rd_a_idx];
   assign rd_b_data = regs[rd_b_idx];

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

   typedef logic [`CPU_REG_AW-1:0] reg_idx_t;
   typedef logic [`CPU_WORD_W-1:0] word_t;

   // register form: rx is written, ry and rz are read
   typedef struct packed {
      logic [`CPU_OPC_W-1:0] opcode;
      reg_idx_t              rx;
      reg_idx_t              ry;
      reg_idx_t              rz;
      logic                  with_carry;
   } reg_fmt_t;

   // jump form, target follows in the next word
   typedef struct packed {
      logic [`CPU_OPC_W-1:0] opcode;
      logic [3:0]            cond;
      logic [5:0]            unused;
   } jmp_fmt_t;

   typedef union packed {
      reg_fmt_t r;
      jmp_fmt_t j;
   } instr_u;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOT,
      ALU_CMP,
      ALU_PASS
   } alu_op_t;

endpackage

`default_nettype wire

//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_WORD_W   16
`define CPU_NREGS    8
`define CPU_REG_AW   3
`define CPU_OPC_W    6

// opcodes, top six bits of the instruction word
`define OPC_LOADN    6'b111000
`define OPC_LOAD     6'b110000
`define OPC_STORE    6'b110001
`define OPC_LOADI    6'b111100
`define OPC_STOREI   6'b111101
`define OPC_MOV      6'b110011
`define OPC_ADD      6'b100000
`define OPC_SUB      6'b100001
`define OPC_AND      6'b010010
`define OPC_OR       6'b010011
`define OPC_XOR      6'b010100
`define OPC_NOT      6'b010101
`define OPC_CMP      6'b010110
`define OPC_JMP      6'b000010

// jump conditions
`define COND_ALWAYS  4'd0
`define COND_EQ      4'd1
`define COND_NE      4'd2
`define COND_Z       4'd3
`define COND_NZ      4'd4
`define COND_C       4'd5
`define COND_NC      4'd6
`define COND_GT      4'd7
`define COND_LT      4'd8

// bit positions in the flag word
`define FLAG_GT      15
`define FLAG_LT      14
`define FLAG_EQ      13
`define FLAG_Z       12
`define FLAG_C       11

`define CPU_PC_RESET 16'h0000

`endif
